/* hw/icy_config.svh */
`ifndef ICY_CONFIG_SVH
`define ICY_CONFIG_SVH

// motion pacing, clocks per tick
`define ICY_TICK_DIV     8

// map and player geometry, y grows downward
`define ICY_MAP_W        256
`define ICY_PLAYER_W     16
`define ICY_START_X      40
`define ICY_FLOOR_Y      200

// physics per tick
`define ICY_STEP         2
`define ICY_JUMP_SPEED   6

// floor tiles
`define ICY_TILE_W       32
`define ICY_TILE_COUNT   8

// snowflakes
`define ICY_SNOW_COUNT   4
`define ICY_SNOW_X0      24
`define ICY_SNOW_PITCH   64
`define ICY_SNOW_Y       185

// keyboard scan codes
`define ICY_KEY_W        8'h1D
`define ICY_KEY_A        8'h1C
`define ICY_KEY_S        8'h1B
`define ICY_KEY_D        8'h23
`define ICY_KEY_R        8'h2D

`endif

/* hw/icy_pkg.sv */
`include "icy_config.svh"

package icy_pkg;

    // pixel coordinates of the player's top-left corner
    typedef logic [8:0] xpos_t;
    typedef logic [8:0] ypos_t;

    // vertical velocity, negative is upward
    typedef logic signed [5:0] vel_t;

    // round state
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        PLAY = 2'd1,
        WIN  = 2'd2
    } game_state_t;

    // wide enough to hold every flake collected
    typedef logic [$clog2(`ICY_SNOW_COUNT + 1)-1:0] score_t;

endpackage

/* hw/key_command.sv */
`include "icy_config.svh"

module key_command (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       key_valid_i,
    input  logic [7:0] key_code_i,
    output logic       move_left_o,
    output logic       move_right_o,
    output logic       jump_held_o,
    output logic       start_req_o
);

    logic is_r;
    logic is_w;
    logic is_a;
    logic is_d;

    assign is_r = (key_code_i == `ICY_KEY_R);
    assign is_w = (key_code_i == `ICY_KEY_W);
    assign is_a = (key_code_i == `ICY_KEY_A);
    assign is_d = (key_code_i == `ICY_KEY_D);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            move_left_o  <= 1'b0;
            move_right_o <= 1'b0;
            jump_held_o  <= 1'b0;
            start_req_o  <= 1'b0;
        end else begin
            start_req_o <= 1'b0;
            if (key_valid_i) begin
                if (is_r) begin
                    // restart key leaves the held flags untouched
                    start_req_o <= 1'b1;
                end else begin
                    // last key wins, S and unknown codes release everything
                    jump_held_o  <= is_w;
                    move_left_o  <= is_a;
                    move_right_o <= is_d;
                end
            end
        end
    end

endmodule

/* hw/player_motion.sv */
`include "icy_config.svh"

module player_motion import icy_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  round_start_i,
    input  logic  playing_i,
    input  logic  move_left_i,
    input  logic  move_right_i,
    input  logic  jump_held_i,
    output xpos_t x_o,
    output ypos_t y_o,
    output logic  on_ground_o
);

    localparam int TICK_W = $clog2(`ICY_TICK_DIV);
    localparam xpos_t X_MAX = xpos_t'(`ICY_MAP_W - `ICY_PLAYER_W);
    localparam xpos_t STEP = xpos_t'(`ICY_STEP);
    localparam ypos_t FLOOR_Y = ypos_t'(`ICY_FLOOR_Y);
    localparam vel_t JUMP_VEL = vel_t'(-(`ICY_JUMP_SPEED));

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    vel_t              vel_q;
    xpos_t             x_next;
    logic signed [10:0] y_sum;

    assign tick = (tick_cnt == TICK_W'(`ICY_TICK_DIV - 1));

    // tick divider, realigned at every round start
    always_ff @(posedge clk) begin
        if (!rst_n_i || round_start_i) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign on_ground_o = (y_o == FLOOR_Y) && (vel_q == '0);

    // horizontal step with clamp at both edges
    always_comb begin
        x_next = x_o;
        if (move_left_i) begin
            x_next = (x_o < STEP) ? '0 : x_o - STEP;
        end else if (move_right_i) begin
            x_next = (x_o > X_MAX - STEP) ? X_MAX : x_o + STEP;
        end
    end

    // candidate y after applying velocity, kept signed
    assign y_sum = $signed({2'b00, y_o}) + $signed({{5{vel_q[5]}}, vel_q});

    always_ff @(posedge clk) begin
        if (!rst_n_i || round_start_i) begin
            x_o   <= xpos_t'(`ICY_START_X);
            y_o   <= FLOOR_Y;
            vel_q <= '0;
        end else if (tick && playing_i) begin
            x_o <= x_next;
            if (on_ground_o) begin
                // launch, y holds for this tick
                if (jump_held_i) begin
                    vel_q <= JUMP_VEL;
                end
            end else if (y_sum >= $signed(11'(`ICY_FLOOR_Y))) begin
                // landing snaps onto the floor row
                y_o   <= FLOOR_Y;
                vel_q <= '0;
            end else begin
                y_o   <= ypos_t'(y_sum[8:0]);
                vel_q <= vel_q + vel_t'(1);
            end
        end
    end

endmodule

/* hw/tile_freeze.sv */
`include "icy_config.svh"

module tile_freeze import icy_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       round_start_i,
    input  logic                       playing_i,
    input  xpos_t                      x_i,
    input  logic                       on_ground_i,
    output logic [`ICY_TILE_COUNT-1:0] frozen_o,
    output logic                       all_frozen_o
);

    logic [9:0]                 x_left;
    logic [9:0]                 x_right;
    logic [`ICY_TILE_COUNT-1:0] hit;

    // player span, one bit wider so the right edge cannot wrap
    assign x_left  = {1'b0, x_i};
    assign x_right = x_left + 10'(`ICY_PLAYER_W - 1);

    genvar i;
    generate
        for (i = 0; i < `ICY_TILE_COUNT; i++) begin : g_tile
            localparam int LO = i * `ICY_TILE_W;
            localparam int HI = LO + `ICY_TILE_W - 1;

            // spans overlap when neither lies wholly past the other
            assign hit[i] = playing_i && on_ground_i
                            && (x_left <= 10'(HI))
                            && (x_right >= 10'(LO));
        end
    endgenerate

    // frozen bits are sticky for the round
    always_ff @(posedge clk) begin
        if (!rst_n_i || round_start_i) begin
            frozen_o <= '0;
        end else begin
            frozen_o <= frozen_o | hit;
        end
    end

    assign all_frozen_o = &frozen_o;

endmodule

/* hw/snowflake_collect.sv */
`include "icy_config.svh"

module snowflake_collect import icy_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       round_start_i,
    input  logic                       playing_i,
    input  xpos_t                      x_i,
    input  ypos_t                      y_i,
    output logic [`ICY_SNOW_COUNT-1:0] collected_o,
    output score_t                     score_o
);

    logic [9:0]                 x_left;
    logic [9:0]                 x_right;
    logic                       high_enough;
    logic [`ICY_SNOW_COUNT-1:0] hit;
    logic [`ICY_SNOW_COUNT-1:0] mask_next;
    score_t                     score_next;

    assign x_left      = {1'b0, x_i};
    assign x_right     = x_left + 10'(`ICY_PLAYER_W - 1);
    // y grows downward, so above the row means a smaller value
    assign high_enough = (y_i <= ypos_t'(`ICY_SNOW_Y));

    genvar j;
    generate
        for (j = 0; j < `ICY_SNOW_COUNT; j++) begin : g_flake
            localparam int FX = `ICY_SNOW_X0 + j * `ICY_SNOW_PITCH;

            assign hit[j] = playing_i && high_enough
                            && (x_left <= 10'(FX))
                            && (x_right >= 10'(FX));
        end
    endgenerate

    assign mask_next = collected_o | hit;

    // score follows the updated mask in the same cycle
    always_comb begin
        score_next = '0;
        for (int k = 0; k < `ICY_SNOW_COUNT; k++) begin
            score_next = score_next + score_t'(mask_next[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || round_start_i) begin
            collected_o <= '0;
            score_o     <= '0;
        end else begin
            collected_o <= mask_next;
            score_o     <= score_next;
        end
    end

endmodule

/* hw/game_control.sv */
`include "icy_config.svh"

module game_control import icy_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        start_req_i,
    input  logic        all_frozen_i,
    output game_state_t state_o,
    output logic        round_start_o,
    output logic        playing_o
);

    game_state_t state_next;

    // a start request only counts outside a running round
    assign round_start_o = start_req_i && (state_o != PLAY);
    assign playing_o     = (state_o == PLAY);

    always_comb begin
        state_next = state_o;
        case (state_o)
            IDLE, WIN: begin
                if (round_start_o) begin
                    state_next = PLAY;
                end
            end
            PLAY: begin
                if (all_frozen_i) begin
                    state_next = WIN;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_o <= IDLE;
        end else begin
            state_o <= state_next;
        end
    end

endmodule

/* hw/icy_top.sv */
`include "icy_config.svh"

module icy_top import icy_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       key_valid_i,
    input  logic [7:0]                 key_code_i,
    output xpos_t                      player_x_o,
    output ypos_t                      player_y_o,
    output logic [`ICY_TILE_COUNT-1:0] frozen_o,
    output logic [`ICY_SNOW_COUNT-1:0] collected_o,
    output score_t                     score_o,
    output game_state_t                state_o
);

    logic move_left;
    logic move_right;
    logic jump_held;
    logic start_req;
    logic round_start;
    logic playing;
    logic on_ground;
    logic all_frozen;

    key_command u_key_command (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .move_left_o  (move_left),
        .move_right_o (move_right),
        .jump_held_o  (jump_held),
        .start_req_o  (start_req)
    );

    game_control u_game_control (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_req_i   (start_req),
        .all_frozen_i  (all_frozen),
        .state_o       (state_o),
        .round_start_o (round_start),
        .playing_o     (playing)
    );

    player_motion u_player_motion (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .round_start_i (round_start),
        .playing_i     (playing),
        .move_left_i   (move_left),
        .move_right_i  (move_right),
        .jump_held_i   (jump_held),
        .x_o           (player_x_o),
        .y_o           (player_y_o),
        .on_ground_o   (on_ground)
    );

    tile_freeze u_tile_freeze (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .round_start_i (round_start),
        .playing_i     (playing),
        .x_i           (player_x_o),
        .on_ground_i   (on_ground),
        .frozen_o      (frozen_o),
        .all_frozen_o  (all_frozen)
    );

    snowflake_collect u_snowflake_collect (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .round_start_i (round_start),
        .playing_i     (playing),
        .x_i           (player_x_o),
        .y_i           (player_y_o),
        .collected_o   (collected_o),
        .score_o       (score_o)
    );

endmodule

/* test/icy_chk.sv */
`include "icy_config.svh"

module icy_chk import icy_pkg::*; (
    input logic                       clk,
    input logic                       rst_n_i,
    input game_state_t                state_i,
    input logic                       start_req_i,
    input logic                       round_start_i,
    input logic [`ICY_TILE_COUNT-1:0] frozen_i,
    input logic [`ICY_SNOW_COUNT-1:0] collected_i,
    input score_t                     score_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // WIN is left only for a new round
    win_exit_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_i == WIN) |=> (state_i == WIN) || ((state_i == PLAY) && $past(start_req_i)))
    else begin
        $error("state left WIN without a start request");
        fail_count++;
    end

    score_range_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        score_i <= score_t'(`ICY_SNOW_COUNT))
    else begin
        $error("score above the snowflake count");
        fail_count++;
    end

    // masks only grow within a round
    frozen_keep_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !round_start_i |=> ((frozen_i & $past(frozen_i)) == $past(frozen_i)))
    else begin
        $error("frozen tile lost outside a round start");
        fail_count++;
    end

    collected_keep_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !round_start_i |=> ((collected_i & $past(collected_i)) == $past(collected_i)))
    else begin
        $error("collected flake lost outside a round start");
        fail_count++;
    end

endmodule

bind icy_top icy_chk chk (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .state_i       (state_o),
    .start_req_i   (start_req),
    .round_start_i (round_start),
    .frozen_i      (frozen_o),
    .collected_i   (collected_o),
    .score_i       (score_o)
);

/* test/icy_tb.sv */
`include "icy_config.svh"

module icy_tb import icy_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int RAND_CYCLES = 4000;
    localparam int X_MAX       = `ICY_MAP_W - `ICY_PLAYER_W;
    localparam int WALK_CYCLES = (X_MAX / `ICY_STEP + 2) * `ICY_TICK_DIV;
    localparam int WATCHDOG_NS = (RAND_CYCLES + 4 * WALK_CYCLES + 600) * CLK_PERIOD;
    localparam int JUMP_RISE   = `ICY_JUMP_SPEED * (`ICY_JUMP_SPEED + 1) / 2;

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic                       key_valid_i;
    logic [7:0]                 key_code_i;
    xpos_t                      player_x_o;
    ypos_t                      player_y_o;
    logic [`ICY_TILE_COUNT-1:0] frozen_o;
    logic [`ICY_SNOW_COUNT-1:0] collected_o;
    score_t                     score_o;
    game_state_t                state_o;
    integer                     seed;

    // reference model state
    int                         m_x;
    int                         m_y;
    int                         m_vel;
    int                         m_tick;
    logic                       m_left;
    logic                       m_right;
    logic                       m_jump;
    logic                       m_start;
    game_state_t                m_state;
    logic [`ICY_TILE_COUNT-1:0] m_frozen;
    logic [`ICY_SNOW_COUNT-1:0] m_collected;

    icy_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .player_x_o  (player_x_o),
        .player_y_o  (player_y_o),
        .frozen_o    (frozen_o),
        .collected_o (collected_o),
        .score_o     (score_o),
        .state_o     (state_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                      name, actual, expected));
        end
    endtask

    task automatic clear_round();
        m_x         = `ICY_START_X;
        m_y         = `ICY_FLOOR_Y;
        m_vel       = 0;
        m_tick      = 0;
        m_frozen    = '0;
        m_collected = '0;
    endtask

    task automatic reset_model();
        clear_round();
        m_left  = 1'b0;
        m_right = 1'b0;
        m_jump  = 1'b0;
        m_start = 1'b0;
        m_state = IDLE;
    endtask

    // one clock of the game rules with every term taken from the values before the edge
    task automatic step_model(input logic kv, input logic [7:0] kc);
        logic                       restart;
        logic                       playing;
        logic                       grounded;
        logic                       tick;
        logic [`ICY_TILE_COUNT-1:0] tile_hit;
        logic [`ICY_SNOW_COUNT-1:0] flake_hit;
        int                         edge_x;

        restart  = m_start && (m_state != PLAY);
        playing  = (m_state == PLAY);
        grounded = (m_y == `ICY_FLOOR_Y) && (m_vel == 0);
        tick     = (m_tick == `ICY_TICK_DIV - 1);
        for (int i = 0; i < `ICY_TILE_COUNT; i++) begin
            edge_x      = i * `ICY_TILE_W;
            tile_hit[i] = playing && grounded && (m_x < edge_x + `ICY_TILE_W)
                          && (m_x + `ICY_PLAYER_W > edge_x);
        end
        for (int j = 0; j < `ICY_SNOW_COUNT; j++) begin
            edge_x       = `ICY_SNOW_X0 + j * `ICY_SNOW_PITCH;
            flake_hit[j] = playing && (m_y <= `ICY_SNOW_Y) && (edge_x >= m_x)
                           && (edge_x < m_x + `ICY_PLAYER_W);
        end

        if (restart) begin
            clear_round();
            m_state = PLAY;
        end else begin
            if (playing && (&m_frozen)) begin
                m_state = WIN;
            end
            if (tick && playing) begin
                if (m_left) begin
                    m_x = (m_x < `ICY_STEP) ? 0 : m_x - `ICY_STEP;
                end else if (m_right) begin
                    m_x = (m_x + `ICY_STEP > X_MAX) ? X_MAX : m_x + `ICY_STEP;
                end
                if (grounded) begin
                    if (m_jump) begin
                        m_vel = -`ICY_JUMP_SPEED;
                    end
                end else if (m_y + m_vel >= `ICY_FLOOR_Y) begin
                    m_y   = `ICY_FLOOR_Y;
                    m_vel = 0;
                end else begin
                    m_y   = m_y + m_vel;
                    m_vel = m_vel + 1;
                end
            end
            m_tick      = tick ? 0 : m_tick + 1;
            m_frozen    = m_frozen | tile_hit;
            m_collected = m_collected | flake_hit;
        end

        m_start = kv && (kc == `ICY_KEY_R);
        if (kv && (kc != `ICY_KEY_R)) begin
            m_jump  = (kc == `ICY_KEY_W);
            m_left  = (kc == `ICY_KEY_A);
            m_right = (kc == `ICY_KEY_D);
        end
    endtask

    task automatic check_outputs();
        check_value("player_x_o", 32'(player_x_o), 32'(m_x));
        check_value("player_y_o", 32'(player_y_o), 32'(m_y));
        check_value("frozen_o", 32'(frozen_o), 32'(m_frozen));
        check_value("collected_o", 32'(collected_o), 32'(m_collected));
        check_value("score_o", 32'(score_o), 32'($countones(m_collected)));
        check_value("state_o", 32'(state_o), 32'(m_state));
    endtask

    // drive, let the edge pass, then compare against the model
    task automatic run_cycle(input logic kv, input logic [7:0] kc);
        key_valid_i = kv;
        key_code_i  = kc;
        @(posedge clk);
        if (!rst_n_i) begin
            reset_model();
        end else begin
            step_model(kv, kc);
        end
        #2;
        check_outputs();
    endtask

    // idle cycles in the held direction until x hits the target or the round is won
    task automatic walk_to_x(input int target);
        int n;

        n = 0;
        while ((int'(player_x_o) != target) && (state_o != WIN)) begin
            if (n == WALK_CYCLES) begin
                stop_on_failure($sformatf("player never reached x = %0d", target));
            end
            run_cycle(1'b0, 8'h00);
            n++;
        end
    endtask

    // R kept rare so that rounds can run on
    function automatic logic [7:0] pick_code(input logic [3:0] sel);
        logic [7:0] code;

        if (sel < 4'd4) begin
            code = `ICY_KEY_W;
        end else if (sel < 4'd8) begin
            code = `ICY_KEY_A;
        end else if (sel < 4'd12) begin
            code = `ICY_KEY_D;
        end else if (sel < 4'd14) begin
            code = `ICY_KEY_S;
        end else if (sel == 4'd14) begin
            code = 8'h5A;
        end else begin
            code = `ICY_KEY_R;
        end
        return code;
    endfunction

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_on_failure($sformatf("timed out after %0d ns without finishing", WATCHDOG_NS));
    end

    initial begin : stimulus
        logic [31:0] r;
        int          n;
        int          apex;

        seed        = 9;
        rst_n_i     = 1'b0;
        key_valid_i = 1'b0;
        key_code_i  = 8'h00;
        reset_model();
        run_cycle(1'b0, 8'h00);
        run_cycle(1'b0, 8'h00);
        rst_n_i = 1'b1;

        run_cycle(1'b1, `ICY_KEY_R);
        for (int k = 0; k < RAND_CYCLES; k++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                run_cycle(1'b1, pick_code(r[5:2]));
            end else begin
                run_cycle(1'b0, r[15:8]);
            end
        end

        // final sweep from the left edge to the right until every tile is frozen
        run_cycle(1'b1, `ICY_KEY_R);
        run_cycle(1'b1, `ICY_KEY_A);
        walk_to_x(0);
        if (state_o == WIN) begin
            // fresh round from the start x so the walk left ends at the edge
            run_cycle(1'b1, `ICY_KEY_R);
            run_cycle(1'b0, 8'h00);
            walk_to_x(0);
        end
        // A still held at the left edge
        repeat (2 * `ICY_TICK_DIV) begin
            run_cycle(1'b0, 8'h00);
        end
        check_value("player_x_o", 32'(player_x_o), 32'h0);
        run_cycle(1'b1, `ICY_KEY_D);
        n = 0;
        while (state_o != WIN) begin
            if (n == WALK_CYCLES) begin
                stop_on_failure("state never reached WIN during the final sweep");
            end
            run_cycle(1'b0, 8'h00);
            n++;
        end

        // restart from WIN clears the field
        run_cycle(1'b1, `ICY_KEY_R);
        run_cycle(1'b0, 8'h00);
        check_value("state_o", 32'(state_o), 32'(PLAY));
        check_value("frozen_o", 32'(frozen_o), 32'h0);
        check_value("score_o", 32'(score_o), 32'h0);

        // with D still held and tile 0 clear the walk ends at the right edge
        walk_to_x(X_MAX);
        repeat (2 * `ICY_TICK_DIV) begin
            run_cycle(1'b0, 8'h00);
        end
        check_value("player_x_o", 32'(player_x_o), 32'(X_MAX));

        // one full jump arc from the floor
        run_cycle(1'b1, `ICY_KEY_W);
        apex = `ICY_FLOOR_Y;
        n    = 0;
        while (player_y_o == ypos_t'(`ICY_FLOOR_Y)) begin
            if (n == 4 * `ICY_TICK_DIV) begin
                stop_on_failure("player never left the floor after W");
            end
            run_cycle(1'b0, 8'h00);
            n++;
        end
        n = 0;
        while (player_y_o != ypos_t'(`ICY_FLOOR_Y)) begin
            if (int'(player_y_o) < apex) begin
                apex = int'(player_y_o);
            end
            if (n == 20 * `ICY_TICK_DIV) begin
                stop_on_failure("player never landed after the jump");
            end
            run_cycle(1'b0, 8'h00);
            n++;
        end
        check_value("jump_apex", 32'(apex), 32'(`ICY_FLOOR_Y - JUMP_RISE));
        run_cycle(1'b1, `ICY_KEY_S);
        run_cycle(1'b0, 8'h00);

        if (dut.chk.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_on_failure($sformatf("%0d assertion failures in the bound checker",
                                      dut.chk.fail_count));
        end
    end

endmodule

/* sources.f */
+incdir+hw
hw/icy_pkg.sv
hw/key_command.sv
hw/player_motion.sv
hw/tile_freeze.sv
hw/snowflake_collect.sv
hw/game_control.sv
hw/icy_top.sv
test/icy_chk.sv
test/icy_tb.sv

/* Makefile */
TOP := icy_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f sources.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
